/* verilog/iob_cache_pkg.sv */
`default_nettype none

package iob_cache_pkg;

   ////////////////////////////////////////
   // front-end bus widths
   ////////////////////////////////////////

   parameter int FE_ADDR_W = 30;        // word address
   parameter int FE_DATA_W = 32;        // word size
   parameter int FE_NBYTES = FE_DATA_W / 8;

   typedef logic [FE_ADDR_W-1:0] fe_addr_t;
   typedef logic [FE_DATA_W-1:0] fe_word_t;
   typedef logic [FE_NBYTES-1:0] fe_strb_t;   // all zero means read

   // stored master request, also the write-through entry
   typedef struct packed
   {
      fe_addr_t addr;
      fe_word_t wdata;
      fe_strb_t wstrb;
   } fe_req_t;

   ////////////////////////////////////////
   // state machines
   ////////////////////////////////////////

   // cache_memory control
   typedef enum logic [1:0]
   {
      ST_LOOKUP,     // tag compare on the stored request
      ST_FILL_REQ,   // miss, waiting for the buffer to drain
      ST_FILL,       // line words coming back
      ST_DONE        // answer with the filled word
   } cache_state_t;

   // back_end_native control
   typedef enum logic [1:0]
   {
      BE_IDLE,
      BE_WRITE,      // draining one buffer entry
      BE_READ        // line fill burst
   } be_state_t;

endpackage

`default_nettype wire

/* verilog/front_end.sv */
`timescale 1ns/1ps
`default_nettype none

module front_end
   import iob_cache_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   // master side
   input  logic     valid,
   input  fe_addr_t addr,
   input  fe_word_t wdata,
   input  fe_strb_t wstrb,
   output fe_word_t rdata,
   output logic     ready,
   // cache memory side
   output logic     data_valid,     // one cycle start pulse
   output fe_addr_t data_addr,      // live address for the data array
   output fe_req_t  data_req_reg,   // stored request
   input  fe_word_t data_rdata,
   input  logic     data_ready
);

   logic busy;      // request in flight
   logic capture;

   assign capture = valid && !busy;

   // live address goes straight to the synchronous data array
   assign data_addr = addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         data_valid <= 1'b0;
      end
      else
      begin
         data_valid <= capture;         // high in the lookup cycle only
         if (capture)
            busy <= 1'b1;
         else if (data_ready)
            busy <= 1'b0;               // answered, free for the next one
      end
   end

   // payload register
   always_ff @(posedge clk)
   begin
      if (capture)
      begin
         data_req_reg.addr  <= addr;
         data_req_reg.wdata <= wdata;
         data_req_reg.wstrb <= wstrb;
      end
   end

   assign ready = data_ready;
   assign rdata = data_rdata;

   // cache core only answers a request that was actually captured
   a_ready_in_flight : assert property (@(posedge clk) disable iff (reset)
      data_ready |-> busy);

endmodule

`default_nettype wire

/* verilog/cache_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_memory
   import iob_cache_pkg::*;
#(
   parameter int LINE_OFF_W = 4,
   parameter int WORD_OFF_W = 2
)
(
   input  logic                  clk,
   input  logic                  reset,
   // front end
   input  logic                  data_valid,
   input  fe_addr_t              data_addr,
   input  fe_req_t               data_req_reg,
   output fe_word_t              data_rdata,
   output logic                  data_ready,
   // write-through buffer
   output logic                  push,
   output fe_req_t               push_req,
   input  logic                  full,
   input  logic                  empty,
   // line replacement
   output logic                  replace_valid,
   output fe_addr_t              replace_addr,
   input  logic                  replace_ready,
   input  logic                  read_valid,
   input  logic [WORD_OFF_W-1:0] read_addr,
   input  fe_word_t              read_rdata
);

   localparam int IDX_W  = LINE_OFF_W + WORD_OFF_W;
   localparam int TAG_W  = FE_ADDR_W - IDX_W;
   localparam int NLINES = 2 ** LINE_OFF_W;
   localparam int NWORDS = 2 ** IDX_W;

   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [LINE_OFF_W-1:0] line_t;
   typedef logic [WORD_OFF_W-1:0] woff_t;
   typedef logic [IDX_W-1:0]      idx_t;

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////

   logic [NLINES-1:0] line_valid;
   tag_t              tag_mem  [NLINES];
   fe_word_t          data_mem [NWORDS];
   fe_word_t          data_rd;          // registered read of the live address

   cache_state_t state;
   logic         req_pend;              // request waiting past its lookup cycle
   fe_word_t     fill_word;             // requested word caught during fill

   // stored request split into fields
   tag_t  req_tag;
   line_t req_line;
   woff_t req_woff;
   logic  active;
   logic  is_write;
   logic  hit;

   assign req_tag  = data_req_reg.addr[FE_ADDR_W-1:IDX_W];
   assign req_line = data_req_reg.addr[IDX_W-1:WORD_OFF_W];
   assign req_woff = data_req_reg.addr[WORD_OFF_W-1:0];
   assign active   = data_valid || req_pend;
   assign is_write = |data_req_reg.wstrb;
   assign hit      = line_valid[req_line] && (tag_mem[req_line] == req_tag);

   // data array single write port
   logic     wr_en;
   idx_t     wr_idx;
   fe_word_t wr_data;
   fe_strb_t wr_strb;

   ////////////////////////////////////////
   // control outputs
   ////////////////////////////////////////

   always_comb
   begin
      push          = 1'b0;
      data_ready    = 1'b0;
      replace_valid = 1'b0;
      wr_en         = 1'b0;
      wr_idx        = {req_line, req_woff};
      wr_data       = data_req_reg.wdata;
      wr_strb       = data_req_reg.wstrb;
      case (state)
         ST_LOOKUP:
         begin
            if (active && is_write && !full)
            begin
               push       = 1'b1;      // every write goes through
               data_ready = 1'b1;
               wr_en      = hit;       // no allocate on write miss
            end
            else if (active && !is_write && hit)
               data_ready = 1'b1;
         end
         ST_FILL_REQ:
            replace_valid = empty;     // only once buffer has drained
         ST_FILL:
         begin
            replace_valid = 1'b1;
            wr_en         = read_valid;
            wr_idx        = {req_line, read_addr};
            wr_data       = read_rdata;
            wr_strb       = '1;
         end
         ST_DONE:
            data_ready = 1'b1;
         default:
            data_ready = 1'b0;
      endcase
   end

   assign push_req     = data_req_reg;
   assign replace_addr = {req_tag, req_line, {WORD_OFF_W{1'b0}}};   // line base
   assign data_rdata   = (state == ST_DONE) ? fill_word : data_rd;

   ////////////////////////////////////////
   // state machine
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= ST_LOOKUP;
         req_pend   <= 1'b0;
         line_valid <= '0;
      end
      else
      begin
         if (data_ready)
            req_pend <= 1'b0;
         else if (data_valid)
            req_pend <= 1'b1;
         case (state)
            ST_LOOKUP:
               if (active && !is_write && !hit)
                  state <= ST_FILL_REQ;  // read miss
            ST_FILL_REQ:
               if (empty)
                  state <= ST_FILL;
            ST_FILL:
               if (replace_ready)
               begin
                  state                <= ST_DONE;
                  line_valid[req_line] <= 1'b1;
               end
            ST_DONE:
               state <= ST_LOOKUP;
            default:
               state <= ST_LOOKUP;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_FILL && replace_ready)
         tag_mem[req_line] <= req_tag;
      if (state == ST_FILL && read_valid && read_addr == req_woff)
         fill_word <= read_rdata;    // keep the word the master asked for
   end

   // byte strobed data array read every cycle with the live address
   always_ff @(posedge clk)
   begin
      if (wr_en)
         for (int b = 0; b < FE_NBYTES; b++)
            if (wr_strb[b])
               data_mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
      data_rd <= data_mem[data_addr[IDX_W-1:0]];
   end

   // write stalled on a full buffer keeps its request until pushed
   a_full_stall_held : assert property (@(posedge clk) disable iff (reset)
      active && is_write && full |=> active && $stable(data_req_reg));

   // buffer must stay empty for the whole fill
   a_fill_empty : assert property (@(posedge clk) disable iff (reset)
      replace_valid |-> empty);

endmodule

`default_nettype wire

/* verilog/write_through_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_through_buffer
   import iob_cache_pkg::*;
#(
   parameter int WTBUF_DEPTH_W = 3
)
(
   input  logic    clk,
   input  logic    reset,
   input  logic    push,
   input  fe_req_t push_req,
   input  logic    pop,
   output fe_req_t pop_req,     // oldest entry
   output logic    full,
   output logic    empty
);

   localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

   typedef logic [WTBUF_DEPTH_W-1:0] ptr_t;
   typedef logic [WTBUF_DEPTH_W:0]   cnt_t;   // one extra bit for full

   fe_req_t fifo_mem [DEPTH];
   ptr_t    wr_ptr;
   ptr_t    rd_ptr;
   cnt_t    count;

   assign full    = (count == cnt_t'(DEPTH));
   assign empty   = (count == '0);
   assign pop_req = fifo_mem[rd_ptr];

   // pointers wrap naturally at the power of two depth
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or neither
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wr_ptr] <= push_req;
   end

   a_no_pop_empty : assert property (@(posedge clk) disable iff (reset)
      pop |-> !empty);

endmodule

`default_nettype wire

/* verilog/back_end_native.sv */
`timescale 1ns/1ps
`default_nettype none

module back_end_native
   import iob_cache_pkg::*;
#(
   parameter int WORD_OFF_W = 2
)
(
   input  logic                  clk,
   input  logic                  reset,
   // write-through buffer
   input  fe_req_t               pop_req,
   input  logic                  empty,
   output logic                  pop,
   // line replacement
   input  logic                  replace_valid,
   input  fe_addr_t              replace_addr,
   output logic                  replace_ready,
   output logic                  read_valid,
   output logic [WORD_OFF_W-1:0] read_addr,
   output fe_word_t              read_rdata,
   // native memory port
   output logic                  mem_valid,
   output fe_addr_t              mem_addr,
   output fe_word_t              mem_wdata,
   output fe_strb_t              mem_wstrb,
   input  fe_word_t              mem_rdata,
   input  logic                  mem_ready
);

   typedef logic [WORD_OFF_W-1:0] woff_t;

   be_state_t state;
   woff_t     word_cnt;     // fill word index

   ////////////////////////////////////////
   // memory port drive
   ////////////////////////////////////////

   always_comb
   begin
      mem_valid     = 1'b0;
      mem_addr      = pop_req.addr;      // head entry by default
      mem_wdata     = pop_req.wdata;
      mem_wstrb     = pop_req.wstrb;
      pop           = 1'b0;
      read_valid    = 1'b0;
      replace_ready = 1'b0;
      case (state)
         BE_WRITE:
         begin
            mem_valid = 1'b1;
            pop       = mem_ready;
         end
         BE_READ:
         begin
            mem_valid     = 1'b1;
            mem_addr      = {replace_addr[FE_ADDR_W-1:WORD_OFF_W], word_cnt};
            mem_wdata     = '0;
            mem_wstrb     = '0;              // read
            read_valid    = mem_ready;
            replace_ready = mem_ready && (&word_cnt);   // last word
         end
         default:
            mem_valid = 1'b0;
      endcase
   end

   assign read_addr  = word_cnt;
   assign read_rdata = mem_rdata;

   ////////////////////////////////////////
   // state machine
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= BE_IDLE;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            BE_IDLE:
               if (!empty)
                  state <= BE_WRITE;     // drains win over fills
               else if (replace_valid)
               begin
                  state    <= BE_READ;
                  word_cnt <= '0;
               end
            BE_WRITE:
               if (mem_ready)
                  state <= BE_IDLE;
            BE_READ:
               if (mem_ready)
               begin
                  word_cnt <= word_cnt + 1'b1;
                  if (&word_cnt)
                     state <= BE_IDLE;
               end
            default:
               state <= BE_IDLE;
         endcase
      end
   end

   // stalled transfer keeps its fields, relies on buffer head and cache request
   a_mem_stable : assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid && $stable({mem_addr, mem_wdata, mem_wstrb}));

endmodule

`default_nettype wire

/* verilog/iob_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module iob_cache
   import iob_cache_pkg::*;
#(
   parameter int LINE_OFF_W    = 4,   // 2**LINE_OFF_W lines
   parameter int WORD_OFF_W    = 2,   // 2**WORD_OFF_W words per line
   parameter int WTBUF_DEPTH_W = 3    // write-through buffer depth
)
(
   input  logic     clk,
   input  logic     reset,
   // master
   input  logic     valid,
   input  fe_addr_t addr,
   input  fe_word_t wdata,
   input  fe_strb_t wstrb,
   output fe_word_t rdata,
   output logic     ready,
   // memory
   output logic     mem_valid,
   output fe_addr_t mem_addr,
   output fe_word_t mem_wdata,
   output fe_strb_t mem_wstrb,
   input  fe_word_t mem_rdata,
   input  logic     mem_ready
);

   // front end to core
   logic     data_valid;
   logic     data_ready;
   fe_addr_t data_addr;
   fe_req_t  data_req_reg;
   fe_word_t data_rdata;

   // write-through path
   logic    push;
   logic    pop;
   logic    full;
   logic    empty;
   fe_req_t push_req;
   fe_req_t pop_req;

   // line fill path
   logic                  replace_valid;
   logic                  replace_ready;
   fe_addr_t              replace_addr;
   logic                  read_valid;
   logic [WORD_OFF_W-1:0] read_addr;
   fe_word_t              read_rdata;

   front_end front_end
   (
      .clk          (clk),
      .reset        (reset),
      .valid        (valid),
      .addr         (addr),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .rdata        (rdata),
      .ready        (ready),
      .data_valid   (data_valid),
      .data_addr    (data_addr),
      .data_req_reg (data_req_reg),
      .data_rdata   (data_rdata),
      .data_ready   (data_ready)
   );

   cache_memory #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W)
   ) cache_memory
   (
      .clk           (clk),
      .reset         (reset),
      .data_valid    (data_valid),
      .data_addr     (data_addr),
      .data_req_reg  (data_req_reg),
      .data_rdata    (data_rdata),
      .data_ready    (data_ready),
      .push          (push),
      .push_req      (push_req),
      .full          (full),
      .empty         (empty),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata)
   );

   write_through_buffer #(
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) write_through_buffer
   (
      .clk      (clk),
      .reset    (reset),
      .push     (push),
      .push_req (push_req),
      .pop      (pop),
      .pop_req  (pop_req),
      .full     (full),
      .empty    (empty)
   );

   back_end_native #(
      .WORD_OFF_W (WORD_OFF_W)
   ) back_end
   (
      .clk           (clk),
      .reset         (reset),
      .pop_req       (pop_req),
      .empty         (empty),
      .pop           (pop),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .mem_valid     (mem_valid),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_wstrb     (mem_wstrb),
      .mem_rdata     (mem_rdata),
      .mem_ready     (mem_ready)
   );

endmodule

`default_nettype wire

/* dv/iob_cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module iob_cache_checker
   import iob_cache_pkg::*;
#(
   parameter int          LINE_OFF_W = 4,
   parameter int          WORD_OFF_W = 2,
   parameter logic [31:0] INIT_KEY   = 32'h0   // pattern of memory never written
)
(
   input  logic         clk,
   input  logic         reset,
   input  logic [127:0] test_name,
   // master port
   input  logic         valid,
   input  fe_addr_t     addr,
   input  fe_word_t     wdata,
   input  fe_strb_t     wstrb,
   input  fe_word_t     rdata,
   input  logic         ready,
   // memory port
   input  logic         mem_valid,
   input  fe_addr_t     mem_addr,
   input  fe_word_t     mem_wdata,
   input  fe_strb_t     mem_wstrb,
   input  logic         mem_ready,
   // results
   output int           checks,
   output int           errors,
   output int           pending     // accepted writes not yet seen on the memory port
);

   localparam int IDX_W  = LINE_OFF_W + WORD_OFF_W;
   localparam int NLINES = 2 ** LINE_OFF_W;
   localparam int NWORDS = 2 ** WORD_OFF_W;

   typedef logic [FE_ADDR_W-IDX_W-1:0] tag_t;
   typedef logic [WORD_OFF_W-1:0]      woff_t;

   fe_word_t          shadow [fe_addr_t];   // memory as the master sees it
   fe_req_t           wr_queue [$];         // acceptance order
   logic [NLINES-1:0] line_valid;           // expected residency, direct mapped
   tag_t              line_tag [NLINES];
   int                fill_reads;           // memory reads within the current request

   function automatic fe_word_t init_word(input fe_addr_t a);
      return fe_word_t'(a) ^ INIT_KEY;
   endfunction

   function automatic fe_word_t merge_bytes(input fe_word_t old_word, input fe_word_t new_word,
                                            input fe_strb_t strb);
      fe_word_t w;
      w = old_word;
      for (int b = 0; b < FE_NBYTES; b++)
         if (strb[b])
            w[8*b +: 8] = new_word[8*b +: 8];
      return w;
   endfunction

   // reference for any read
   function automatic fe_word_t expected_read(input fe_addr_t a);
      return shadow.exists(a) ? shadow[a] : init_word(a);
   endfunction

   ////////////////////////////////////////
   // compare, mid cycle where all is stable
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      fe_req_t               req;
      fe_addr_t              exp_addr;
      fe_word_t              exp_word;
      int                    exp_fills;
      logic [LINE_OFF_W-1:0] line;
      logic                  hit;
      if (reset)
      begin
         line_valid = '0;
         fill_reads = 0;
         wr_queue.delete();
      end
      else
      begin
         // memory side completes on the coming edge
         if (mem_valid && mem_ready && mem_wstrb != '0)
         begin
            checks++;
            req = {mem_addr, mem_wdata, mem_wstrb};
            if (wr_queue.size() == 0)
            begin
               errors++;
               $display("Error in %0s: memory write to %h with no master write left",
                        test_name, mem_addr);
            end
            else
            begin
               if (wr_queue[0] != req)
               begin
                  errors++;
                  $display("Mismatch %0s write order: expected %h, actual %h",
                           test_name, wr_queue[0], req);
               end
               void'(wr_queue.pop_front());
            end
         end
         else if (mem_valid && mem_ready)
         begin
            checks++;
            exp_addr = {addr[FE_ADDR_W-1:WORD_OFF_W], woff_t'(fill_reads)};  // line aligned
            if (mem_addr !== exp_addr)
            begin
               errors++;
               $display("Mismatch %0s fill address: expected %h, actual %h",
                        test_name, exp_addr, mem_addr);
            end
            fill_reads++;
         end
         // master side
         if (valid && ready)
         begin
            line = addr[IDX_W-1:WORD_OFF_W];
            if (wstrb != '0)
            begin
               exp_fills = 0;                               // no allocate on writes
               wr_queue.push_back({addr, wdata, wstrb});
               shadow[addr] = merge_bytes(expected_read(addr), wdata, wstrb);
            end
            else
            begin
               hit = line_valid[line] && (line_tag[line] == addr[FE_ADDR_W-1:IDX_W]);
               exp_fills = hit ? 0 : NWORDS;                // whole line on a miss
               line_valid[line] = 1'b1;
               line_tag[line]   = addr[FE_ADDR_W-1:IDX_W];
               exp_word = expected_read(addr);
               checks++;
               if (rdata !== exp_word)
               begin
                  errors++;
                  $display("Mismatch %0s read %h: expected %h, actual %h",
                           test_name, addr, exp_word, rdata);
               end
            end
            checks++;
            if (fill_reads != exp_fills)
            begin
               errors++;
               $display("Mismatch %0s fill reads at %h: expected %0d, actual %0d",
                        test_name, addr, exp_fills, fill_reads);
            end
            fill_reads = 0;
         end
      end
      pending = wr_queue.size();
   end

endmodule

`default_nettype wire

/* dv/iob_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module iob_cache_tb
   import iob_cache_pkg::*;
();

   localparam int LINE_OFF_W    = 4;
   localparam int WORD_OFF_W    = 2;
   localparam int WTBUF_DEPTH_W = 3;
   localparam int IDX_W         = LINE_OFF_W + WORD_OFF_W;
   localparam int NWORDS        = 2 ** WORD_OFF_W;

   localparam logic [31:0] SEED      = 32'h44ce;
   localparam logic [31:0] LFSR_POLY = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] INIT_KEY  = 32'h5ca1_ab1e;

   localparam int     BURST_LEN  = 40;
   localparam int     MIX_LEN    = 60;
   localparam int     NUM_OPS    = 4 + 4 * (NWORDS - 1) + 16 + 8 + 10 + 2 * BURST_LEN + MIX_LEN;
   localparam longint TIMEOUT_NS = longint'(NUM_OPS) * 40 * 100;   // 40 cycles per op

   logic         clk = 1'b0;
   logic         reset;
   logic         valid;
   fe_addr_t     addr;
   fe_word_t     wdata;
   fe_strb_t     wstrb;
   fe_word_t     rdata;
   logic         ready;
   logic         mem_valid;
   fe_addr_t     mem_addr;
   fe_word_t     mem_wdata;
   fe_strb_t     mem_wstrb;
   fe_word_t     mem_rdata = '0;
   logic         mem_ready = 1'b0;
   logic [127:0] test_name;
   int           checks;
   int           errors;
   int           pending;

   logic [31:0] stim_lfsr = SEED;      // master stimulus stream
   logic [31:0] lat_lfsr  = SEED;      // memory latency stream
   fe_word_t    mem_model [fe_addr_t];
   logic        ready_nxt = 1'b0;
   fe_word_t    rdata_nxt = '0;
   logic [1:0]  delay_cnt = '0;

   always #50 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ LFSR_POLY;
      return s >> 1;
   endfunction

   // one step per bit taken
   task automatic draw(input int n, inout logic [31:0] state, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits  = {bits[30:0], state[0]};
         state = lfsr_step(state);
      end
   endtask

   function automatic fe_word_t init_word(input fe_addr_t a);
      return fe_word_t'(a) ^ INIT_KEY;
   endfunction

   function automatic fe_word_t apply_strobe(input fe_word_t old_word, input fe_word_t new_word,
                                             input fe_strb_t strb);
      fe_word_t w;
      w = old_word;
      for (int b = 0; b < FE_NBYTES; b++)
         if (strb[b])
            w[8*b +: 8] = new_word[8*b +: 8];
      return w;
   endfunction

   function automatic fe_word_t mem_word(input fe_addr_t a);
      return mem_model.exists(a) ? mem_model[a] : init_word(a);
   endfunction

   function automatic fe_addr_t win_addr(input int tag, input int line, input int word);
      return (fe_addr_t'(tag) << IDX_W) | (fe_addr_t'(line) << WORD_OFF_W) | fe_addr_t'(word);
   endfunction

   // small window, tags 0..2 over lines 0..3
   task automatic rand_addr(output fe_addr_t a);
      logic [31:0] t;
      logic [31:0] l;
      logic [31:0] w;
      draw(2, stim_lfsr, t);
      draw(2, stim_lfsr, l);
      draw(WORD_OFF_W, stim_lfsr, w);
      a = win_addr(int'(t % 3), int'(l), int'(w));
   endtask

   task automatic rand_data(output fe_word_t d, output fe_strb_t s);
      logic [31:0] bits;
      draw(32, stim_lfsr, bits);
      d = bits;
      draw(FE_NBYTES, stim_lfsr, bits);
      s = fe_strb_t'(bits);
      if (s == '0)
         s = '1;                       // keep it a write
   endtask

   task automatic start_test(input logic [127:0] name);
      @(posedge clk);
      valid     <= 1'b0;
      wstrb     <= '0;
      test_name <= name;
   endtask

   // hold the request until ready, seen mid cycle
   task automatic master_xfer(input fe_addr_t a, input fe_word_t d, input fe_strb_t s);
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      @(negedge clk);
      while (!ready)
         @(negedge clk);
   endtask

   task automatic do_read(input fe_addr_t a);
      master_xfer(a, '0, '0);
   endtask

   task automatic do_write(input fe_addr_t a, input fe_word_t d, input fe_strb_t s);
      master_xfer(a, d, s);
   endtask

   ////////////////////////////////////////
   // memory model, random latency 0..3
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      logic [31:0] bits;
      if (reset)
      begin
         ready_nxt = 1'b0;
         delay_cnt = '0;
      end
      else if (mem_ready)
      begin
         // transfer completes on the coming edge
         if (mem_wstrb != '0)
            mem_model[mem_addr] = apply_strobe(mem_word(mem_addr), mem_wdata, mem_wstrb);
         ready_nxt = 1'b0;
         draw(2, lat_lfsr, bits);
         delay_cnt = bits[1:0];
      end
      else if (mem_valid)
      begin
         if (delay_cnt == '0)
         begin
            ready_nxt = 1'b1;
            rdata_nxt = mem_word(mem_addr);
         end
         else
            delay_cnt = delay_cnt - 1'b1;
      end
   end

   always @(posedge clk)
   begin
      mem_ready <= ready_nxt;
      mem_rdata <= rdata_nxt;
   end

   ////////////////////////////////////////
   // DUT and checker
   ////////////////////////////////////////

   iob_cache #(
      .LINE_OFF_W    (LINE_OFF_W),
      .WORD_OFF_W    (WORD_OFF_W),
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) dut0
   (
      .clk       (clk),
      .reset     (reset),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   iob_cache_checker #(
      .LINE_OFF_W (LINE_OFF_W),
      .WORD_OFF_W (WORD_OFF_W),
      .INIT_KEY   (INIT_KEY)
   ) checker0
   (
      .clk       (clk),
      .reset     (reset),
      .test_name (test_name),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready),
      .checks    (checks),
      .errors    (errors),
      .pending   (pending)
   );

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial
   begin
      fe_addr_t    a;
      fe_word_t    d;
      fe_strb_t    s;
      logic [31:0] bits;
      fe_addr_t    touched [$];
      reset     = 1'b1;
      valid     = 1'b0;
      addr      = '0;
      wdata     = '0;
      wstrb     = '0;
      test_name = "reset";
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      start_test("cold_reads");
      for (int l = 0; l < 4; l++)
         do_read(win_addr(0, l, 0));             // one fill per line

      start_test("read_hits");
      for (int l = 0; l < 4; l++)
         for (int w = 1; w < NWORDS; w++)
            do_read(win_addr(0, l, w));

      start_test("write_merge");
      for (int i = 0; i < 8; i++)
      begin
         draw(2, stim_lfsr, bits);
         a = win_addr(0, int'(bits), i % NWORDS);
         rand_data(d, s);
         do_write(a, d, s);
         do_read(a);                             // old and new bytes merged
      end

      start_test("write_miss");
      for (int i = 0; i < 4; i++)
      begin
         rand_data(d, s);
         do_write(win_addr(0, 8 + i, i % NWORDS), d, s);   // lines never filled
      end
      for (int i = 0; i < 4; i++)
         do_read(win_addr(0, 8 + i, i % NWORDS));

      start_test("conflict");
      for (int l = 0; l < 2; l++)
      begin
         rand_data(d, s);
         do_write(win_addr(1, l, 1), d, s);      // miss, no allocate
         do_read(win_addr(1, l, 1));             // evicts tag 0
         rand_data(d, s);
         do_write(win_addr(0, l, 1), d, s);
         do_read(win_addr(0, l, 1));             // refill after the buffer drains
         do_read(win_addr(2, l, 2));
      end

      start_test("back_pressure");
      for (int i = 0; i < BURST_LEN; i++)
      begin
         rand_addr(a);
         rand_data(d, s);
         do_write(a, d, s);                      // faster than the drain
         touched.push_back(a);
      end
      foreach (touched[i])
         do_read(touched[i]);

      start_test("random_mix");
      for (int i = 0; i < MIX_LEN; i++)
      begin
         rand_addr(a);
         draw(1, stim_lfsr, bits);
         if (bits[0])
         begin
            rand_data(d, s);
            do_write(a, d, s);
         end
         else
            do_read(a);
      end

      start_test("drain");
      while (pending != 0)
         @(posedge clk);
      repeat (2) @(posedge clk);

      $display("checks %0d, errors %0d, writes left %0d", checks, errors, pending);
      if (errors == 0 && checks > 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      #(TIMEOUT_NS);
      $display("Error: run did not finish within %0d ns, the cache stopped answering",
               TIMEOUT_NS);
      $display("checks %0d, errors %0d, writes left %0d", checks, errors, pending);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
verilog/iob_cache_pkg.sv
verilog/front_end.sv
verilog/cache_memory.sv
verilog/write_through_buffer.sv
verilog/back_end_native.sv
verilog/iob_cache.sv
dv/iob_cache_checker.sv
dv/iob_cache_tb.sv

/* Makefile */
SIM      = verilator
TOP      = iob_cache_tb
FILELIST = sim.f
BUILD    = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD)

BIN  = $(BUILD)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD)
